// File: Bender.yml
package:
  name: matmul_engine

sources:
  - verilog/matmul_pkg.sv
  - verilog/matmul_fsm.sv
  - verilog/matmul_index_counter.sv
  - verilog/mac_datapath.sv
  - verilog/result_writer.sv
  - verilog/matmul_top.sv
  - target: test
    files:
      - test/sram_model.sv
      - test/matmul_tb.sv

// File: test/matmul_tb.sv
// Directed testbench for the matrix-multiply engine
// Loads both SRAM models, starts each run and checks every result write
`timescale 1ns/1ps
`default_nettype none

module matmul_tb import matmul_pkg::*; ();

  localparam sram_addr_t RESULT_BASE    = 16'h0040;
  localparam int         TIMEOUT_CYCLES = 2000;
  localparam int         MAX_WORDS      = 64;

  logic       clk;
  logic       reset_n;
  logic       dut_valid;
  logic       dut_ready;
  sram_addr_t input_rd_addr;
  sram_data_t input_rd_data;
  sram_addr_t weight_rd_addr;
  sram_data_t weight_rd_data;
  result_wr_t result_wr;

  sram_data_t  a_mat [0:MAX_WORDS-1];   // Input matrix as a_mat[i*K + k]
  sram_data_t  b_mat [0:MAX_WORDS-1];   // Weight matrix as b_mat[k*N + j]
  sram_data_t  captured [sram_addr_t];  // Last write seen at each address
  sram_addr_t  write_addrs [$];         // Write addresses in order
  int          write_count;
  logic [31:0] lfsr_state;
  int          error_count;
  int          checks_done;
  int          tests_run;
  int          tests_failed;

  matmul_top #(
    .result_base_addr (RESULT_BASE)
  ) dut0 (
    .clk            (clk),
    .reset_n        (reset_n),
    .dut_valid      (dut_valid),
    .dut_ready      (dut_ready),
    .input_rd_addr  (input_rd_addr),
    .input_rd_data  (input_rd_data),
    .weight_rd_addr (weight_rd_addr),
    .weight_rd_data (weight_rd_data),
    .result_wr      (result_wr)
  );

  sram_model input_sram  (.clk(clk), .rd_addr(input_rd_addr),  .rd_data(input_rd_data));
  sram_model weight_sram (.clk(clk), .rd_addr(weight_rd_addr), .rd_data(weight_rd_data));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Result write monitor
  always @(posedge clk) begin
    if (reset_n === 1'b1 && result_wr.enable === 1'b1) begin
      captured[result_wr.addr] = result_wr.data;
      write_addrs.push_back(result_wr.addr);
      write_count++;
    end
  end

  // --------------------
  // Stimulus helpers
  // --------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function sram_data_t random_bits(input int n);
    sram_data_t v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      v = {v[SRAM_DATA_WIDTH-2:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Reference dot product with sums wrapping mod 2^32
  function automatic sram_data_t expected_dot(input int i, input int j,
                                              input int k_dim, input int n_dim);
    sram_data_t acc;
    acc = '0;
    for (int kk = 0; kk < k_dim; kk++)
      acc = acc + a_mat[i*k_dim + kk] * b_mat[kk*n_dim + j];
    return acc;
  endfunction

  task automatic load_srams(input int r, input int k, input int n);
    mat_dims_t in_hdr;
    mat_dims_t wt_hdr;
    in_hdr.rows = dim_t'(r);
    in_hdr.cols = dim_t'(k);
    wt_hdr.rows = dim_t'(k);
    wt_hdr.cols = dim_t'(n);
    input_sram.fill_pattern();
    weight_sram.fill_pattern();
    input_sram.load_word('0, sram_data_t'(in_hdr));
    weight_sram.load_word('0, sram_data_t'(wt_hdr));
    for (int i = 0; i < r; i++)
      for (int kk = 0; kk < k; kk++)
        input_sram.load_word(sram_addr_t'(1 + i*k + kk), a_mat[i*k + kk]);
    // Weights column-major with one run of K words per column
    for (int j = 0; j < n; j++)
      for (int kk = 0; kk < k; kk++)
        weight_sram.load_word(sram_addr_t'(1 + j*k + kk), b_mat[kk*n + j]);
  endtask

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_data(input string what, input sram_data_t actual,
                            input sram_data_t expected);
    checks_done++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_addr(input string what, input sram_addr_t actual,
                            input sram_addr_t expected);
    checks_done++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_count(input string what, input int actual, input int expected);
    checks_done++;
    if (actual != expected) begin
      error_count++;
      $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic check_flag(input string what, input logic actual, input logic expected);
    checks_done++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  // Polls once per cycle 1 ns after the edge
  task automatic wait_ready(input logic level, input string why, output bit ok);
    int cycles;
    cycles = 0;
    ok     = 1'b1;
    while (dut_ready !== level) begin
      if (cycles == TIMEOUT_CYCLES) begin
        error_count++;
        ok = 1'b0;
        $display("Timeout at %0t ns: dut_ready did not go %b while %s", $time, level, why);
        return;
      end
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic run_and_check(input int r, input int k, input int n);
    bit         ok;
    int         idx;
    sram_addr_t addr;
    captured.delete();
    write_addrs.delete();
    write_count = 0;
    load_srams(r, k, n);
    wait_ready(1'b1, "waiting to start a run", ok);
    if (!ok) return;
    dut_valid = 1'b1;  // One cycle pulse
    @(posedge clk);
    #1;
    dut_valid = 1'b0;
    wait_ready(1'b0, "starting a run", ok);
    if (!ok) return;
    wait_ready(1'b1, "finishing a run", ok);
    if (!ok) return;
    // Header address on both buses while idle
    check_addr("input read address when idle", input_rd_addr, '0);
    check_addr("weight read address when idle", weight_rd_addr, '0);
    check_count("write count", write_count, r*n);
    for (int i = 0; i < r; i++) begin
      for (int j = 0; j < n; j++) begin
        idx  = i*n + j;
        addr = RESULT_BASE + sram_addr_t'(idx);  // Row-major from the base
        if (idx < write_addrs.size())
          check_addr($sformatf("address of write %0d", idx), write_addrs[idx], addr);
        if (captured.exists(addr)) begin
          check_data($sformatf("result[%0d][%0d]", i, j), captured[addr],
                     expected_dot(i, j, k, n));
        end else begin
          error_count++;
          $display("At %0t ns no result was written for row %0d column %0d", $time, i, j);
        end
      end
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, error_count - errors_before);
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic reset_sequence();
    int errors_before;
    bit ok;
    errors_before = error_count;
    for (int c = 0; c < 5; c++) begin
      @(posedge clk);
      #1;
      check_flag("dut_ready in reset", dut_ready, 1'b0);
      check_flag("write enable in reset", result_wr.enable, 1'b0);
    end
    reset_n = 1'b1;
    wait_ready(1'b1, "leaving reset", ok);
    report_test("reset", errors_before);
  endtask

  task automatic smallest_product();
    int errors_before;
    errors_before = error_count;
    a_mat[0] = 32'h0001_0003;
    b_mat[0] = 32'h0003_0005;  // Product wraps
    run_and_check(1, 1, 1);
    report_test("smallest 1x1", errors_before);
  endtask

  task automatic fixed_product();
    int errors_before;
    errors_before = error_count;
    for (int w = 0; w < 6; w++) begin
      a_mat[w] = sram_data_t'(w + 1);  // 1 2 3 / 4 5 6
      b_mat[w] = sram_data_t'(w + 7);  // 7 8 / 9 10 / 11 12
    end
    run_and_check(2, 3, 2);
    report_test("fixed 2x3 by 3x2", errors_before);
  endtask

  task automatic random_product();
    int errors_before;
    errors_before = error_count;
    for (int w = 0; w < 20; w++)
      a_mat[w] = random_bits(32);
    for (int w = 0; w < 15; w++)
      b_mat[w] = random_bits(32);
    a_mat[0] = 32'hFFFF_FFFF;
    run_and_check(4, 5, 3);
    report_test("random 4x5 by 5x3", errors_before);
  endtask

  task automatic back_to_back_runs();
    int errors_before;
    errors_before = error_count;
    for (int w = 0; w < 4; w++) begin
      a_mat[w] = random_bits(8);
      b_mat[w] = random_bits(8);
    end
    run_and_check(3, 1, 4);
    for (int w = 0; w < 4; w++) begin
      a_mat[w] = random_bits(8);
      b_mat[w] = random_bits(8);
    end
    run_and_check(2, 2, 2);  // Addresses restart at the base
    report_test("back-to-back runs", errors_before);
  endtask

  initial begin
    reset_n      = 1'b0;
    dut_valid    = 1'b0;
    lfsr_state   = 32'h1069;
    write_count  = 0;
    error_count  = 0;
    checks_done  = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset_sequence();
    smallest_product();
    fixed_product();
    random_product();
    back_to_back_runs();
    $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, checks_done, error_count);
    if (error_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/sram_model.sv
// Behavioral read SRAM with one cycle of read latency
// The testbench fills it through fill_pattern and load_word before each run
`timescale 1ns/1ps
`default_nettype none

module sram_model import matmul_pkg::*; (
  input  wire        clk,
  input  wire  sram_addr_t rd_addr,
  output sram_data_t rd_data
);

  localparam int DEPTH = 1 << SRAM_ADDR_WIDTH;

  sram_data_t mem [0:DEPTH-1];

  initial rd_data = '0;

  // Word for an address appears after the next rising edge
  always @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // --------------------
  // Load tasks
  // --------------------
  // Background that differs at every address, so a stray read shows up
  task automatic fill_pattern();
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = {~sram_addr_t'(a), sram_addr_t'(a)};
    end
  endtask

  task automatic load_word(input sram_addr_t addr, input sram_data_t data);
    mem[addr] = data;
  endtask

endmodule

`default_nettype wire

// File: verilog.f
verilog/matmul_pkg.sv
verilog/matmul_fsm.sv
verilog/matmul_index_counter.sv
verilog/mac_datapath.sv
verilog/result_writer.sv
verilog/matmul_top.sv
test/sram_model.sv
test/matmul_tb.sv

// File: verilog/mac_datapath.sv
// Multiply-accumulate stage of the engine
// Lines the operand tag up with the SRAM read data and flags finished dot products
`timescale 1ns/1ps
`default_nettype none

module mac_datapath import matmul_pkg::*; (
  input  wire        clk,
  input  wire        reset_n,
  input  wire  mac_tag_t   tag,
  input  wire  sram_data_t input_rd_data,
  input  wire  sram_data_t weight_rd_data,
  output sram_data_t result,
  output logic       result_valid
);

  mac_tag_t   tag_q;    // Tag of the data now on the read buses
  sram_data_t product;
  sram_data_t sum;
  sram_data_t acc;

  // --------------------
  // Tag alignment
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n)
      tag_q <= '0;
    else
      tag_q <= tag;  // One cycle of SRAM read latency
  end

  // --------------------
  // MAC
  // --------------------
  assign product = input_rd_data * weight_rd_data;         // Wraps mod 2^32
  assign sum     = tag_q.first ? product : product + acc;  // Restart on first term

  always_ff @(posedge clk) begin
    if (tag_q.valid)
      acc <= sum;
  end

  assign result       = sum;
  assign result_valid = tag_q.valid && tag_q.last;

  // A continuing term always follows another term of the same walk
  term_continuity: assert property (
    @(posedge clk) disable iff (!reset_n)
    (tag_q.valid && !tag_q.first) |-> $past(tag_q.valid)
  );

endmodule

`default_nettype wire

// File: verilog/matmul_fsm.sv
// Control state machine for the matrix-multiply engine
// Owns the ready level and the load and compute phase strobes
`timescale 1ns/1ps
`default_nettype none

module matmul_fsm (
  input  wire  clk,
  input  wire  reset_n,
  input  wire  dut_valid,
  input  wire  walk_done,   // Final address pair issued this cycle
  output logic dut_ready,
  output logic load_dims,
  output logic run
);

  localparam logic [1:0] DRAIN_CYCLES = 2'd2;  // Sum stage plus write stage

  typedef enum logic [2:0] {
    IDLE,
    READ_DIMS,
    LOAD_DIMS,
    COMPUTE,
    DRAIN
  } state_t;

  state_t     state;
  state_t     state_next;
  logic [1:0] drain_cnt;

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_next = state;
    case (state)
      IDLE:      if (dut_valid) state_next = READ_DIMS;
      READ_DIMS: state_next = LOAD_DIMS;   // Header address on both buses
      LOAD_DIMS: state_next = COMPUTE;
      COMPUTE:   if (walk_done) state_next = DRAIN;
      DRAIN:     if (drain_cnt == 2'd0) state_next = IDLE;
      default:   state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= IDLE;
      drain_cnt <= 2'd0;
      dut_ready <= 1'b0;
    end else begin
      state     <= state_next;
      dut_ready <= (state == IDLE);  // Level follows the idle state
      if (state == COMPUTE && walk_done)
        drain_cnt <= DRAIN_CYCLES - 2'd1;
      else if (state == DRAIN && drain_cnt != 2'd0)
        drain_cnt <= drain_cnt - 2'd1;
    end
  end

  assign load_dims = (state == LOAD_DIMS);
  assign run       = (state == COMPUTE);

  // Ready must never overlap the address walk
  ready_not_in_run: assert property (
    @(posedge clk) disable iff (!reset_n) !(dut_ready && run)
  );

endmodule

`default_nettype wire

// File: verilog/matmul_index_counter.sv
// Address generator for the input and weight SRAMs
// Captures both header words, then walks k inside j inside i, one pair per cycle
`timescale 1ns/1ps
`default_nettype none

module matmul_index_counter import matmul_pkg::*; (
  input  wire        clk,
  input  wire        reset_n,
  input  wire        load_dims,
  input  wire        run,
  input  wire  sram_data_t input_rd_data,
  input  wire  sram_data_t weight_rd_data,
  output sram_addr_t input_rd_addr,
  output sram_addr_t weight_rd_addr,
  output mac_tag_t   tag,
  output logic       walk_done
);

  mat_dims_t  in_hdr;     // Header words as they arrive
  mat_dims_t  wt_hdr;
  mat_dims_t  in_dims;    // R x K
  mat_dims_t  wt_dims;    // K x N
  dim_t       k_cnt;
  dim_t       j_cnt;
  dim_t       i_cnt;
  sram_addr_t in_base;    // 1 + i*K
  sram_addr_t wt_base;    // 1 + j*K
  logic       k_last;
  logic       j_last;
  logic       i_last;

  // --------------------
  // Dimensions
  // --------------------
  assign in_hdr = mat_dims_t'(input_rd_data);
  assign wt_hdr = mat_dims_t'(weight_rd_data);

  always_ff @(posedge clk) begin
    if (load_dims) begin
      in_dims <= in_hdr;   // Header word read during READ_DIMS
      wt_dims <= wt_hdr;
    end
  end

  assign k_last = (k_cnt == in_dims.cols - dim_t'(1));
  assign j_last = (j_cnt == wt_dims.cols - dim_t'(1));
  assign i_last = (i_cnt == in_dims.rows - dim_t'(1));

  // --------------------
  // Iterators
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n || load_dims) begin
      k_cnt   <= '0;
      j_cnt   <= '0;
      i_cnt   <= '0;
      in_base <= sram_addr_t'(1);
      wt_base <= sram_addr_t'(1);
    end else if (run) begin
      if (!k_last) begin
        k_cnt <= k_cnt + dim_t'(1);
      end else begin
        k_cnt <= '0;
        if (!j_last) begin
          j_cnt   <= j_cnt + dim_t'(1);
          wt_base <= wt_base + sram_addr_t'(in_dims.cols);  // Next weight column
        end else begin
          // Rewind the weight matrix after each row
          j_cnt   <= '0;
          wt_base <= sram_addr_t'(1);
          i_cnt   <= i_cnt + dim_t'(1);
          in_base <= in_base + sram_addr_t'(in_dims.cols);
        end
      end
    end
  end

  // Header words are read whenever the walk is not running
  assign input_rd_addr  = run ? in_base + sram_addr_t'(k_cnt) : '0;
  assign weight_rd_addr = run ? wt_base + sram_addr_t'(k_cnt) : '0;

  assign tag.valid = run;
  assign tag.first = run && (k_cnt == '0);
  assign tag.last  = run && k_last;

  assign walk_done = run && k_last && j_last && i_last;

  // Inner dimensions must agree
  inner_dims_match: assert property (
    @(posedge clk) disable iff (!reset_n)
    load_dims |-> (wt_hdr.rows == in_hdr.cols)
  );

endmodule

`default_nettype wire

// File: verilog/matmul_pkg.sv
// Shared widths, vector types and bus structs for the matrix-multiply engine
// Imported by every RTL module and by the testbench
`default_nettype none

package matmul_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int SRAM_ADDR_WIDTH = 16;
  localparam int SRAM_DATA_WIDTH = 32;
  localparam int DIM_WIDTH       = 16;

  typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;  // One SRAM address
  typedef logic [SRAM_DATA_WIDTH-1:0] sram_data_t;  // One SRAM word or result
  typedef logic [DIM_WIDTH-1:0]       dim_t;        // Row or column count

  // Header word layout, rows in the upper half
  typedef struct packed {
    dim_t rows;
    dim_t cols;
  } mat_dims_t;

  // Travels with each operand address pair
  typedef struct packed {
    logic valid;  // A term exists
    logic first;  // First term of a dot product
    logic last;   // Last term of a dot product
  } mac_tag_t;

  // Result SRAM write port
  typedef struct packed {
    logic       enable;
    sram_addr_t addr;
    sram_data_t data;
  } result_wr_t;

endpackage

`default_nettype wire

// File: verilog/matmul_top.sv
// Top level of the matrix-multiply engine
// Connects the state machine, address walk, MAC and result write port
`timescale 1ns/1ps
`default_nettype none

module matmul_top import matmul_pkg::*; #(
  parameter sram_addr_t result_base_addr = '0   // First result SRAM address
) (
  input  wire        clk,
  input  wire        reset_n,

  // Control
  input  wire        dut_valid,
  output logic       dut_ready,

  // Input SRAM read port
  output sram_addr_t input_rd_addr,
  input  wire  sram_data_t input_rd_data,

  // Weight SRAM read port
  output sram_addr_t weight_rd_addr,
  input  wire  sram_data_t weight_rd_data,

  // Result SRAM write port
  output result_wr_t result_wr
);

  logic       walk_done;
  logic       load_dims;
  logic       run;
  mac_tag_t   tag;
  sram_data_t result;
  logic       result_valid;

  // --------------------
  // Control
  // --------------------
  matmul_fsm u_fsm (
    .clk       (clk),
    .reset_n   (reset_n),
    .dut_valid (dut_valid),
    .walk_done (walk_done),
    .dut_ready (dut_ready),
    .load_dims (load_dims),
    .run       (run)
  );

  matmul_index_counter u_index (
    .clk            (clk),
    .reset_n        (reset_n),
    .load_dims      (load_dims),
    .run            (run),
    .input_rd_data  (input_rd_data),
    .weight_rd_data (weight_rd_data),
    .input_rd_addr  (input_rd_addr),
    .weight_rd_addr (weight_rd_addr),
    .tag            (tag),
    .walk_done      (walk_done)
  );

  // --------------------
  // Data
  // --------------------
  mac_datapath u_mac (
    .clk            (clk),
    .reset_n        (reset_n),
    .tag            (tag),
    .input_rd_data  (input_rd_data),
    .weight_rd_data (weight_rd_data),
    .result         (result),
    .result_valid   (result_valid)
  );

  result_writer #(
    .result_base_addr (result_base_addr)
  ) u_writer (
    .clk          (clk),
    .reset_n      (reset_n),
    .load_dims    (load_dims),
    .result       (result),
    .result_valid (result_valid),
    .result_wr    (result_wr)
  );

endmodule

`default_nettype wire

// File: verilog/result_writer.sv
// Result SRAM write port of the engine
// Registers each finished dot product and steps the write address from the base
`timescale 1ns/1ps
`default_nettype none

module result_writer import matmul_pkg::*; #(
  parameter sram_addr_t result_base_addr = '0
) (
  input  wire        clk,
  input  wire        reset_n,
  input  wire        load_dims,     // Start of a new run
  input  wire  sram_data_t result,
  input  wire        result_valid,
  output result_wr_t result_wr
);

  sram_addr_t next_addr;  // Address for the next write
  logic       wr_en_q;
  sram_addr_t wr_addr_q;
  sram_data_t wr_data_q;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_en_q   <= 1'b0;
      next_addr <= result_base_addr;
    end else begin
      wr_en_q <= result_valid;
      if (load_dims)
        next_addr <= result_base_addr;  // Each run writes from the base
      else if (result_valid)
        next_addr <= next_addr + sram_addr_t'(1);
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (result_valid) begin
      wr_addr_q <= next_addr;
      wr_data_q <= result;
    end
  end

  assign result_wr = '{enable: wr_en_q, addr: wr_addr_q, data: wr_data_q};

  enable_known: assert property (
    @(posedge clk) disable iff (!reset_n) !$isunknown(result_wr.enable)
  );

endmodule

`default_nettype wire
